// File: verilog/bp_cfg_pkg.sv
package bp_cfg_pkg;

    // Byte offset inside a 32-bit instruction word.
    localparam int PC_OFFSET = 2;

    // Chooser table sizing.
    localparam int CHOOSE_IDX_BITS = 5;

    // Gshare sizing; history is as long as the index.
    localparam int GLOBAL_IDX_BITS = 6;
    localparam int GHR_BITS = GLOBAL_IDX_BITS;

    // Local predictor sizing.
    localparam int LOCAL_IDX_BITS = 5;
    localparam int LOCAL_ROWS = 2**LOCAL_IDX_BITS;
    localparam int LHIST_BITS = 6;              // Also the pattern table index.

endpackage : bp_cfg_pkg

// File: verilog/bp_types_pkg.sv
package bp_types_pkg;

    typedef logic [31:0] rv32i_word;

    typedef logic [1:0] ctr_t;                  // MSB is the taken guess.

    localparam ctr_t CTR_SNT = 2'b00;
    localparam ctr_t CTR_WNT = 2'b01;           // Reset value.
    localparam ctr_t CTR_ST = 2'b11;

    typedef enum logic [1:0] {
        sl,                                     // Strong local.
        wl,                                     // Weak local, reset value.
        wg,                                     // Weak global.
        sg                                      // Strong global.
    } choose_t;

    typedef struct packed {
        rv32i_word raddr;
    } bp_query_t;

    typedef struct packed {
        logic      update;
        logic      br_en;
        rv32i_word waddr;
    } bp_resolve_t;

    typedef struct packed {
        logic br_take;
        logic mispred;
    } bp_result_t;

    // One saturating step toward the resolved outcome.
    function automatic ctr_t ctr_step(ctr_t cur, logic taken);
        ctr_t nxt;
        nxt = cur;
        if (taken && cur != CTR_ST) begin
            nxt = cur + 2'd1;
        end else if (!taken && cur != CTR_SNT) begin
            nxt = cur - 2'd1;
        end
        return nxt;
    endfunction

endpackage : bp_types_pkg

// File: verilog/sat_table.sv
`timescale 1ns/1ps

module sat_table #(
    parameter type    entry_t   = logic [1:0],
    parameter int     IDX_BITS  = 5,
    parameter entry_t RESET_VAL = entry_t'(0)
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [IDX_BITS-1:0] raddr,
    input  logic [IDX_BITS-1:0] waddr,
    input  logic                we,
    input  entry_t              wdata,
    output entry_t              rdata
);

    localparam int ROWS = 2**IDX_BITS;

    entry_t mem [ROWS];

    // Read sees the state before this cycle's write.
    assign rdata = mem[raddr];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ROWS; i++) begin
                mem[i] <= RESET_VAL;
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

endmodule : sat_table

// File: verilog/gbht.sv
`timescale 1ns/1ps

module gbht
    import bp_cfg_pkg::*;
    import bp_types_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      update,
    input  logic      br_en,
    input  rv32i_word raddr,
    input  rv32i_word waddr,
    output logic      br_take,
    output logic      mispred
);

    logic [GHR_BITS-1:0]        ghr;
    logic [GLOBAL_IDX_BITS-1:0] r_idx;
    logic [GLOBAL_IDX_BITS-1:0] w_idx;
    ctr_t                       r_ctr;
    ctr_t                       w_ctr;
    ctr_t                       w_next;

    assign r_idx = raddr[GLOBAL_IDX_BITS+PC_OFFSET-1:PC_OFFSET] ^ ghr;
    assign w_idx = waddr[GLOBAL_IDX_BITS+PC_OFFSET-1:PC_OFFSET] ^ ghr;

    assign br_take = r_ctr[1];
    assign mispred = w_ctr[1] ^ br_en;
    assign w_next  = ctr_step(w_ctr, br_en);

    // Two copies with identical writes give a read port per side.
    sat_table #(
        .entry_t   (ctr_t),
        .IDX_BITS  (GLOBAL_IDX_BITS),
        .RESET_VAL (CTR_WNT)
    ) pred_tbl (
        .clk   (clk),
        .rst   (rst),
        .raddr (r_idx),
        .waddr (w_idx),
        .we    (update),
        .wdata (w_next),
        .rdata (r_ctr)
    );

    sat_table #(
        .entry_t   (ctr_t),
        .IDX_BITS  (GLOBAL_IDX_BITS),
        .RESET_VAL (CTR_WNT)
    ) train_tbl (
        .clk   (clk),
        .rst   (rst),
        .raddr (w_idx),
        .waddr (w_idx),
        .we    (update),
        .wdata (w_next),
        .rdata (w_ctr)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            ghr <= '0;
        end else if (update) begin
            ghr <= {ghr[GHR_BITS-2:0], br_en};  // Newest outcome in LSB.
        end
    end

endmodule : gbht

// File: verilog/lbht.sv
`timescale 1ns/1ps

module lbht
    import bp_cfg_pkg::*;
    import bp_types_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      update,
    input  logic      br_en,
    input  rv32i_word raddr,
    input  rv32i_word waddr,
    output logic      br_take,
    output logic      mispred
);

    logic [LHIST_BITS-1:0]     lhist [LOCAL_ROWS];
    logic [LOCAL_IDX_BITS-1:0] r_row;
    logic [LOCAL_IDX_BITS-1:0] w_row;
    logic [LHIST_BITS-1:0]     r_pat;
    logic [LHIST_BITS-1:0]     w_pat;
    ctr_t                      r_ctr;
    ctr_t                      w_ctr;
    ctr_t                      w_next;

    assign r_row = raddr[LOCAL_IDX_BITS+PC_OFFSET-1:PC_OFFSET];
    assign w_row = waddr[LOCAL_IDX_BITS+PC_OFFSET-1:PC_OFFSET];

    assign r_pat = lhist[r_row];
    assign w_pat = lhist[w_row];               // Pre-update history trains.

    assign br_take = r_ctr[1];
    assign mispred = w_ctr[1] ^ br_en;
    assign w_next  = ctr_step(w_ctr, br_en);

    sat_table #(
        .entry_t   (ctr_t),
        .IDX_BITS  (LHIST_BITS),
        .RESET_VAL (CTR_WNT)
    ) pred_pht (
        .clk   (clk),
        .rst   (rst),
        .raddr (r_pat),
        .waddr (w_pat),
        .we    (update),
        .wdata (w_next),
        .rdata (r_ctr)
    );

    sat_table #(
        .entry_t   (ctr_t),
        .IDX_BITS  (LHIST_BITS),
        .RESET_VAL (CTR_WNT)
    ) train_pht (
        .clk   (clk),
        .rst   (rst),
        .raddr (w_pat),
        .waddr (w_pat),
        .we    (update),
        .wdata (w_next),
        .rdata (w_ctr)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < LOCAL_ROWS; i++) begin
                lhist[i] <= '0;
            end
        end else if (update) begin
            lhist[w_row] <= {w_pat[LHIST_BITS-2:0], br_en};
        end
    end

endmodule : lbht

// File: verilog/tournament_p.sv
`timescale 1ns/1ps

module tournament_p
    import bp_cfg_pkg::*;
    import bp_types_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      update,
    input  logic      br_en,
    input  rv32i_word raddr,
    input  rv32i_word waddr,
    output logic      br_take,
    output logic      mispred
);

    logic [CHOOSE_IDX_BITS-1:0] r_row;
    logic [CHOOSE_IDX_BITS-1:0] w_row;
    choose_t                    r_stored;
    choose_t                    r_state;
    choose_t                    w_state;
    choose_t                    state_in;
    logic                       g_br_take;
    logic                       l_br_take;
    logic                       g_mispred;
    logic                       l_mispred;

    assign r_row = raddr[CHOOSE_IDX_BITS+PC_OFFSET-1:PC_OFFSET];
    assign w_row = waddr[CHOOSE_IDX_BITS+PC_OFFSET-1:PC_OFFSET];

    // Forward the pending chooser write to a same-row read.
    assign r_state = (update && r_row == w_row) ? state_in : r_stored;

    assign br_take = (r_state inside {sl, wl}) ? l_br_take : g_br_take;
    assign mispred = (w_state inside {sl, wl}) ? l_mispred : g_mispred;

    gbht gbht (
        .clk     (clk),
        .rst     (rst),
        .update  (update),
        .br_en   (br_en),
        .raddr   (raddr),
        .waddr   (waddr),
        .br_take (g_br_take),
        .mispred (g_mispred)
    );

    lbht lbht (
        .clk     (clk),
        .rst     (rst),
        .update  (update),
        .br_en   (br_en),
        .raddr   (raddr),
        .waddr   (waddr),
        .br_take (l_br_take),
        .mispred (l_mispred)
    );

    // Walk away from the side that alone got it wrong.
    always_comb begin
        state_in = w_state;
        if (l_mispred && !g_mispred) begin
            case (w_state)
                sl:      state_in = wl;
                wl:      state_in = wg;
                default: state_in = sg;
            endcase
        end else if (g_mispred && !l_mispred) begin
            case (w_state)
                sg:      state_in = wg;
                wg:      state_in = wl;
                default: state_in = sl;
            endcase
        end
    end

    sat_table #(
        .entry_t   (choose_t),
        .IDX_BITS  (CHOOSE_IDX_BITS),
        .RESET_VAL (wl)
    ) pred_choice (
        .clk   (clk),
        .rst   (rst),
        .raddr (r_row),
        .waddr (w_row),
        .we    (update),
        .wdata (state_in),
        .rdata (r_stored)
    );

    sat_table #(
        .entry_t   (choose_t),
        .IDX_BITS  (CHOOSE_IDX_BITS),
        .RESET_VAL (wl)
    ) train_choice (
        .clk   (clk),
        .rst   (rst),
        .raddr (w_row),
        .waddr (w_row),
        .we    (update),
        .wdata (state_in),
        .rdata (w_state)
    );

endmodule : tournament_p

// File: verilog/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor
    import bp_types_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  bp_query_t   query,
    input  bp_resolve_t resolve,
    output bp_result_t  result
);

    logic br_take;
    logic mispred;

    tournament_p tournament_p (
        .clk     (clk),
        .rst     (rst),
        .update  (resolve.update),
        .br_en   (resolve.br_en),
        .raddr   (query.raddr),
        .waddr   (resolve.waddr),
        .br_take (br_take),
        .mispred (mispred)
    );

    assign result = '{br_take: br_take, mispred: mispred};

endmodule : branch_predictor

// File: tb/bp_model.svh
logic [1:0] gctr [64] = '{default: 2'd1};      // Weakly not-taken.
logic [1:0] lctr [64] = '{default: 2'd1};
logic [5:0] lhist [32] = '{default: 6'd0};
logic [5:0] ghist = 6'd0;
int         choice [32] = '{default: 1};       // 0 strong local up to 3 strong global.

function automatic logic [1:0] saturate(logic [1:0] c, logic taken);
    int v;
    v = taken ? int'(c) + 1 : int'(c) - 1;
    if (v < 0) v = 0;
    if (v > 3) v = 3;
    return 2'(v);
endfunction

// Gshare uses PC bits 7:2, the per-PC and chooser rows use bits 6:2.
function automatic logic global_guess(logic [31:0] pc);
    return gctr[pc[7:2] ^ ghist][1];
endfunction

function automatic logic local_guess(logic [31:0] pc);
    return lctr[lhist[pc[6:2]]][1];
endfunction

function automatic int next_choice(logic [31:0] pc, logic taken);
    int c;
    c = choice[pc[6:2]];
    if (local_guess(pc) != taken && global_guess(pc) == taken && c < 3) c = c + 1;
    if (global_guess(pc) != taken && local_guess(pc) == taken && c > 0) c = c - 1;
    return c;
endfunction

function automatic logic predict_taken(logic [31:0] ra, logic upd,
                                       logic [31:0] wa, logic taken);
    int c;
    c = choice[ra[6:2]];
    if (upd && ra[6:2] == wa[6:2]) c = next_choice(wa, taken);   // Chooser bypass.
    return (c <= 1) ? local_guess(ra) : global_guess(ra);
endfunction

function automatic logic predict_miss(logic [31:0] wa, logic taken);
    return ((choice[wa[6:2]] <= 1) ? local_guess(wa) : global_guess(wa)) != taken;
endfunction

function automatic void train_tables(logic [31:0] wa, logic taken);
    logic [5:0] gi;
    logic [5:0] li;
    gi = wa[7:2] ^ ghist;
    li = lhist[wa[6:2]];
    choice[wa[6:2]] = next_choice(wa, taken);   // Uses the state before training.
    gctr[gi] = saturate(gctr[gi], taken);
    lctr[li] = saturate(lctr[li], taken);
    lhist[wa[6:2]] = {li[4:0], taken};
    ghist = {ghist[4:0], taken};
endfunction

// File: tb/branch_predictor_tb.sv
`timescale 1ns/1ps

module branch_predictor_tb
    import bp_types_pkg::*;
();

    localparam int CYCLE_LIMIT = 4000;          // About 2220 test cycles plus margin.
    localparam logic [31:0] PC_SAT = 32'h0000_0100;
    localparam logic [31:0] PC_ALT = 32'h0000_0240;
    localparam logic [31:0] PC_BYP = 32'h0000_0ac8;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    bp_query_t   query = '0;
    bp_resolve_t resolve = '0;
    bp_result_t  result;

    int seed = 77;
    int cycles = 0;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int test_base = 0;

    `include "bp_model.svh"

    branch_predictor dut (.clk(clk), .rst(rst), .query(query), .resolve(resolve), .result(result));

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: no result after %0d clock cycles", CYCLE_LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    task automatic check_eq(input logic actual, input logic expected, input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR @%0t: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    // One clock of stimulus, checked mid-cycle while the outputs are settled.
    task automatic run_cycle(input logic [31:0] ra, input logic upd,
                             input logic [31:0] wa, input logic taken);
        @(posedge clk);
        #1;
        query.raddr = ra;
        resolve = '{update: upd, br_en: taken, waddr: wa};
        #4;
        check_eq(result.br_take, predict_taken(ra, upd, wa, taken), "br_take vs model");
        check_eq(result.mispred, predict_miss(wa, taken), "mispred vs model");
        if (upd) train_tables(wa, taken);
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("Test %0d (%s): %s, %0d errors", tests, name,
                 (errors == test_base) ? "ok" : "failed", errors - test_base);
        test_base = errors;
    endtask

    initial begin : stimulus
        logic [31:0] addr;
        logic [31:0] bits;
        logic        tk;
        int          n;
        int          crossings;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int i = 0; i < 32; i++) begin
            addr = rand_word();
            run_cycle(addr, 1'b0, 32'h0, 1'b0);
            check_eq(result.br_take, 1'b0, "br_take after reset");
        end
        addr = rand_word();
        run_cycle(addr, 1'b1, addr, 1'b0);
        check_eq(result.mispred, 1'b0, "mispred on first update");
        finish_test("after reset");

        n = 0;
        while (n < 20 && !predict_taken(PC_SAT, 1'b0, PC_SAT, 1'b0)) begin
            run_cycle(PC_SAT, 1'b1, PC_SAT, 1'b1);
            n++;
        end
        run_cycle(PC_SAT, 1'b0, PC_SAT, 1'b0);
        check_eq(result.br_take, 1'b1, "br_take after taken updates");
        finish_test($sformatf("saturation after %0d strobes", n));

        tk = 1'b0;
        for (int i = 0; i < 60; i++) begin
            tk = ~tk;
            run_cycle(PC_ALT, 1'b1, PC_ALT, tk);
            addr = rand_word();
            if (addr[6:2] == PC_ALT[6:2]) addr[2] = ~addr[2];   // Keep off the local row.
            bits = rand_word();
            run_cycle(PC_ALT, 1'b1, addr, bits[0]);
        end
        finish_test("chooser migration");

        crossings = 0;
        for (int i = 0; i < 32; i++) begin
            bits = rand_word();
            tk = bits[0];
            // Outcome sides with the predictor not in charge.
            if (local_guess(PC_BYP) != global_guess(PC_BYP)) begin
                tk = (choice[PC_BYP[6:2]] <= 1) ? global_guess(PC_BYP) : local_guess(PC_BYP);
            end
            if ((choice[PC_BYP[6:2]] <= 1) != (next_choice(PC_BYP, tk) <= 1)) begin
                crossings++;
            end
            run_cycle(PC_BYP, 1'b1, PC_BYP, tk);
        end
        if (crossings == 0) begin
            errors++;
            $display("Chooser bypass test never moved the chooser across sides");
        end
        finish_test("chooser bypass");

        for (int i = 0; i < 2000; i++) begin
            addr = rand_word();
            bits = rand_word();
            run_cycle(addr, bits[0], rand_word(), bits[1]);
        end
        finish_test("random stream");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule : branch_predictor_tb

// File: branch_predictor.f
+incdir+tb
verilog/bp_cfg_pkg.sv
verilog/bp_types_pkg.sv
verilog/sat_table.sv
verilog/gbht.sv
verilog/lbht.sv
verilog/tournament_p.sv
verilog/branch_predictor.sv
tb/branch_predictor_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps -f branch_predictor.f \
    --top-module branch_predictor_tb -o branch_predictor_sim &&
./obj_dir/branch_predictor_sim | tee /dev/stderr | grep -q "Result: PASSED" &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }
